/* verilog/winograd_cfg.svh */
`ifndef WINOGRAD_CFG_SVH
`define WINOGRAD_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WINO_ACC_W 30 // product and sum width
`define WINO_OUT_W 16
`define WINO_FRAC 8 // dropped on requantization

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile geometry and lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WINO_LANES 2
`define WINO_IN_N 6 // F(4,3) input tile edge
`define WINO_OUT_N 4

`endif

/* verilog/winograd_pkg.sv */
`include "winograd_cfg.svh"

package winograd_pkg;

	// one accumulator word, read as a number or as requant fields
	typedef union packed {
		logic signed [`WINO_ACC_W-1:0] raw;
		struct packed {
			logic sign;
			logic [`WINO_ACC_W-`WINO_OUT_W-`WINO_FRAC-2:0] guard; // overflow bits
			logic [`WINO_OUT_W-1:0] value;
			logic [`WINO_FRAC-1:0] frac;
		} q;
	} acc_word_u;

	// product tile row on its way in
	typedef struct packed {
		logic last;
		acc_word_u [`WINO_IN_N-1:0] word;
	} tile_row_in_t;

	// requantized output row
	typedef struct packed {
		logic last;
		logic [`WINO_OUT_N-1:0][`WINO_OUT_W-1:0] data;
	} tile_row_out_t;

endpackage

/* verilog/winograd_adder_tree.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module winograd_adder_tree
	import winograd_pkg::*;
(
	input  logic      clk,
	input  acc_word_u i_data [6],
	output acc_word_u o_sum
);

	logic [`WINO_ACC_W-1:0] s1 [3]; // pair sums
	logic [`WINO_ACC_W-1:0] s2 [2];

	// all sums wrap at the accumulator width
	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			s1[i] <= i_data[2*i].raw + i_data[2*i+1].raw;
		end
		s2[0] <= s1[0] + s1[1];
		s2[1] <= s1[2]; // odd one out waits a stage
		o_sum.raw <= s2[0] + s2[1];
	end

endmodule

/* verilog/winograd_inverse_lane.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module winograd_inverse_lane
	import winograd_pkg::*;
(
	input  logic          clk,
	input  logic          i_reset,
	input  tile_row_in_t  i_row,
	input  logic          i_wr,
	output logic          o_ready,
	input  logic [1:0]    i_rd_idx,
	output tile_row_out_t o_out_row,
	output logic          o_tile_valid,
	input  logic          i_release
);

	localparam logic [1:0] ST_LOAD   = 2'd0;
	localparam logic [1:0] ST_DRAIN  = 2'd1;
	localparam logic [1:0] ST_SERIAL = 2'd2;
	localparam logic [1:0] ST_HOLD   = 2'd3;
	localparam logic [1:0] LAST_COL  = 2'(`WINO_OUT_N - 1);

	logic [1:0] state;
	logic       wr_ok;
	logic [2:0] p1_vld; // follows the first-pass adder stages
	logic [2:0] p1_last;
	logic [2:0] p2_vld;
	logic [1:0] p2_col [3];
	logic [1:0] ser_cnt;

	acc_word_u p1_sum [`WINO_OUT_N];
	acc_word_u p2_sum [`WINO_OUT_N];
	acc_word_u [`WINO_OUT_N-1:0] buf_q [`WINO_IN_N]; // rows of M*A
	logic [`WINO_OUT_N-1:0][`WINO_OUT_W-1:0] tile_q [`WINO_OUT_N];

	// one entry of A^T row k times input c, by shifts and negation only
	function automatic acc_word_u at_term(input acc_word_u x, input int k, input int c);
		acc_word_u t;
		t.raw = '0;
		case (c)
			0: if (k == 0) t.raw = x.raw;
			1, 2: t.raw = x.raw;
			3, 4: t.raw = x.raw << k;
			default: if (k == 3) t.raw = x.raw;
		endcase
		if ((c == 2 || c == 4) && k[0])
			t.raw = -t.raw; // odd rows alternate sign
		return t;
	endfunction

	// relu, then keep bits 23..8
	function automatic logic [`WINO_OUT_W-1:0] relu_q(input acc_word_u s);
		return s.q.sign ? '0 : s.q.value;
	endfunction

	assign o_ready = (state == ST_LOAD);
	assign wr_ok = i_wr && o_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// both passes, one tree per output index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar k = 0; k < `WINO_OUT_N; k++) begin : g_pass
		acc_word_u p1_in [`WINO_IN_N];
		acc_word_u p2_in [`WINO_IN_N];

		always_comb begin
			for (int c = 0; c < `WINO_IN_N; c++) begin
				p1_in[c] = at_term(i_row.word[c], k, c);
				p2_in[c] = at_term(buf_q[c][ser_cnt], k, c); // column ser_cnt of M*A
			end
		end

		winograd_adder_tree winograd_adder_tree_p1_inst (
			.clk    (clk),
			.i_data (p1_in),
			.o_sum  (p1_sum[k])
		);

		winograd_adder_tree winograd_adder_tree_p2_inst (
			.clk    (clk),
			.i_data (p2_in),
			.o_sum  (p2_sum[k])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= ST_LOAD;
			p1_vld <= '0;
			p2_vld <= '0;
			ser_cnt <= '0;
			o_tile_valid <= 1'b0;
		end else begin
			p1_vld <= {p1_vld[1:0], wr_ok};
			p2_vld <= {p2_vld[1:0], state == ST_SERIAL};
			if (p2_vld[2] && p2_col[2] == LAST_COL)
				o_tile_valid <= 1'b1;
			case (state)
				ST_LOAD: begin
					if (wr_ok && i_row.last)
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					if (p1_vld[2] && p1_last[2]) begin // last M*A row lands now
						state <= ST_SERIAL;
						ser_cnt <= '0;
					end
				end
				ST_SERIAL: begin
					ser_cnt <= ser_cnt + 2'd1;
					if (ser_cnt == LAST_COL)
						state <= ST_HOLD;
				end
				default: begin
					if (i_release) begin
						state <= ST_LOAD;
						o_tile_valid <= 1'b0;
					end
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		p1_last <= {p1_last[1:0], i_row.last};
		p2_col[0] <= ser_cnt;
		p2_col[1] <= p2_col[0];
		p2_col[2] <= p2_col[1];
		if (p1_vld[2]) begin
			for (int r = 0; r < `WINO_IN_N - 1; r++) begin
				buf_q[r] <= buf_q[r+1];
			end
			for (int k = 0; k < `WINO_OUT_N; k++) begin
				buf_q[`WINO_IN_N-1][k] <= p1_sum[k]; // newest row at the top
			end
		end
		// second pass yields one column of Y per cycle
		if (p2_vld[2]) begin
			for (int k = 0; k < `WINO_OUT_N; k++) begin
				tile_q[k][p2_col[2]] <= relu_q(p2_sum[k]);
			end
		end
	end

	always_comb begin
		o_out_row.last = (i_rd_idx == LAST_COL);
		o_out_row.data = tile_q[i_rd_idx];
	end

endmodule

/* verilog/tile_dispatcher.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module tile_dispatcher
	import winograd_pkg::*;
(
	input  logic                   clk,
	input  logic                   i_reset,
	input  tile_row_in_t           i_row,
	input  logic                   i_valid,
	output logic                   o_ready,
	output tile_row_in_t           o_lane_row,
	output logic [`WINO_LANES-1:0] o_lane_wr,
	input  logic [`WINO_LANES-1:0] i_lane_ready
);

	localparam int LANE_W = (`WINO_LANES > 1) ? $clog2(`WINO_LANES) : 1;
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`WINO_LANES - 1);
	localparam logic [2:0] LAST_ROW = 3'(`WINO_IN_N - 1);

	logic [2:0]        row_cnt;
	logic [LANE_W-1:0] ptr;
	logic              accept;

	// stall while the next lane in turn is still busy
	assign o_ready = i_lane_ready[ptr];
	assign accept = i_valid && o_ready;

	always_comb begin
		o_lane_row = i_row;
		o_lane_row.last = (row_cnt == LAST_ROW); // source leaves it low
		o_lane_wr = '0;
		if (accept)
			o_lane_wr[ptr] = 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// row count and round-robin pointer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (i_reset) begin
			row_cnt <= '0;
			ptr <= '0;
		end else if (accept) begin
			if (row_cnt == LAST_ROW) begin
				row_cnt <= '0;
				ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1; // whole tile sent
			end else begin
				row_cnt <= row_cnt + 3'd1;
			end
		end
	end

endmodule

/* verilog/tile_collector.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module tile_collector
	import winograd_pkg::*;
(
	input  logic                   clk,
	input  logic                   i_reset,
	input  tile_row_out_t          i_lane_row [`WINO_LANES],
	input  logic [`WINO_LANES-1:0] i_lane_valid,
	output logic [1:0]             o_rd_idx,
	output logic [`WINO_LANES-1:0] o_release,
	output tile_row_out_t          o_row,
	output logic                   o_valid,
	input  logic                   i_ready
);

	localparam int LANE_W = (`WINO_LANES > 1) ? $clog2(`WINO_LANES) : 1;
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`WINO_LANES - 1);
	localparam logic [1:0] LAST_ROW = 2'(`WINO_OUT_N - 1);

	logic [LANE_W-1:0] ptr;
	logic [1:0]        row_idx;
	logic              accept;
	logic              tile_done;

	assign o_rd_idx = row_idx;
	assign o_valid = i_lane_valid[ptr];
	assign accept = o_valid && i_ready;
	assign tile_done = accept && (row_idx == LAST_ROW);

	// lane tile is held, so the row stays put through a stall
	always_comb begin
		o_row.data = i_lane_row[ptr].data;
		o_row.last = (row_idx == LAST_ROW);
	end

	// frees the lane on the same edge that takes its last row
	always_comb begin
		o_release = '0;
		if (tile_done)
			o_release[ptr] = 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drain order matches the dispatcher
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (i_reset) begin
			ptr <= '0;
			row_idx <= '0;
		end else if (accept) begin
			row_idx <= row_idx + 2'd1; // wraps to row 0
			if (tile_done)
				ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
		end
	end

endmodule

/* verilog/winograd_output_stage.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module winograd_output_stage
	import winograd_pkg::*;
(
	input  logic          clk,
	input  logic          i_reset,
	input  tile_row_in_t  i_row,
	input  logic          i_valid,
	output logic          o_ready,
	output tile_row_out_t o_row,
	output logic          o_valid,
	input  logic          i_ready
);

	tile_row_in_t           lane_row; // shared by all lanes
	logic [`WINO_LANES-1:0] lane_wr;
	logic [`WINO_LANES-1:0] lane_ready;
	logic [`WINO_LANES-1:0] lane_valid;
	logic [`WINO_LANES-1:0] lane_release;
	tile_row_out_t          lane_out [`WINO_LANES];
	logic [1:0]             rd_idx;

	tile_dispatcher tile_dispatcher_inst (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_row        (i_row),
		.i_valid      (i_valid),
		.o_ready      (o_ready),
		.o_lane_row   (lane_row),
		.o_lane_wr    (lane_wr),
		.i_lane_ready (lane_ready)
	);

	for (genvar g = 0; g < `WINO_LANES; g++) begin : g_lane
		winograd_inverse_lane winograd_inverse_lane_inst (
			.clk          (clk),
			.i_reset      (i_reset),
			.i_row        (lane_row),
			.i_wr         (lane_wr[g]),
			.o_ready      (lane_ready[g]),
			.i_rd_idx     (rd_idx),
			.o_out_row    (lane_out[g]),
			.o_tile_valid (lane_valid[g]),
			.i_release    (lane_release[g])
		);
	end

	tile_collector tile_collector_inst (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_lane_row   (lane_out),
		.i_lane_valid (lane_valid),
		.o_rd_idx     (rd_idx),
		.o_release    (lane_release),
		.o_row        (o_row),
		.o_valid      (o_valid),
		.i_ready      (i_ready)
	);

endmodule

/* dv/winograd_output_assertions.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module winograd_output_assertions
	import winograd_pkg::*;
(
	input logic                   clk,
	input logic                   i_reset,
	input logic                   i_out_valid,
	input logic                   i_out_ready,
	input tile_row_out_t          i_out_row,
	input logic                   i_in_ready,
	input logic [`WINO_LANES-1:0] i_lane_wr,
	input logic [`WINO_LANES-1:0] i_lane_ready
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output stream
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_row_hold: assert property (@(posedge clk) disable iff (i_reset)
		(i_out_valid && !i_out_ready) |=> $stable(i_out_row))
		else $error("o_row changed while the output was stalled");

	a_quiet_in_reset: assert property (@(posedge clk)
		(i_reset && $past(i_reset)) |-> !i_out_valid)
		else $error("o_valid high during reset");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// dispatcher side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_strobe_ready: assert property (@(posedge clk) disable iff (i_reset)
		(i_lane_wr & ~i_lane_ready) == '0)
		else $error("row strobe sent to a busy lane");

	a_ready_after_reset: assert property (@(posedge clk)
		$fell(i_reset) |-> i_in_ready) // lane 0 is free
		else $error("o_ready low right after reset");

endmodule

/* dv/tb_winograd_output_stage.sv */
`timescale 1ns/1ps
`include "winograd_cfg.svh"

module tb_winograd_output_stage
	import winograd_pkg::*;
();

	localparam int TILE_WORDS = `WINO_IN_N * `WINO_IN_N + `WINO_OUT_N * `WINO_OUT_N;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 30;
	localparam int TILE_RUNS = 11; // 1 + 4 + 4 + 2 tiles over all tests
	localparam int CYCLES_PER_TILE = 100;
	localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + 2 * IDLE_CYCLES
		+ TILE_RUNS * CYCLES_PER_TILE;

	logic          clk;
	logic          i_reset;
	tile_row_in_t  i_row;
	logic          i_valid;
	logic          o_ready;
	tile_row_out_t o_row;
	logic          o_valid;
	logic          i_ready;

	integer          seed;
	logic [29:0]     golden_mem [0:255];
	tile_row_in_t    in_q [$];
	tile_row_out_t   exp_q [$];
	bit              in_go;
	bit              stall_en;
	bit              out_hold; // keeps i_ready low
	int              cycles;
	int              rows_checked;

	winograd_output_stage winograd_output_stage_inst (
		.clk     (clk),
		.i_reset (i_reset),
		.i_row   (i_row),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.o_row   (o_row),
		.o_valid (o_valid),
		.i_ready (i_ready)
	);

	bind winograd_output_stage winograd_output_assertions winograd_output_assertions_inst (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_out_valid  (o_valid),
		.i_out_ready  (i_ready),
		.i_out_row    (o_row),
		.i_in_ready   (o_ready),
		.i_lane_wr    (lane_wr),
		.i_lane_ready (lane_ready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic compare_row(input tile_row_out_t got, input tile_row_out_t exp);
		if (got !== exp)
			report_failure($sformatf("MISMATCH at %0t: row %0d got last=%0b data=%h, expected last=%0b data=%h",
				$time, rows_checked, got.last, got.data, exp.last, exp.data));
	endtask

	task automatic compare_idle();
		if (o_valid !== 1'b0)
			report_failure($sformatf("MISMATCH at %0t: o_valid high with no tile pending", $time));
	endtask

	// queue the first n_rows of golden tile t, and its results if asked
	task automatic load_tile(input int t, input int n_rows, input bit with_exp);
		tile_row_in_t  r_in;
		tile_row_out_t r_out;
		logic [7:0]    idx;
		for (int r = 0; r < n_rows; r++) begin
			r_in = '0;
			for (int c = 0; c < `WINO_IN_N; c++) begin
				idx = 8'(t * TILE_WORDS + r * `WINO_IN_N + c);
				r_in.word[c].raw = golden_mem[idx];
			end
			in_q.push_back(r_in);
		end
		for (int r = 0; r < `WINO_OUT_N && with_exp; r++) begin
			r_out.last = (r == `WINO_OUT_N - 1);
			for (int j = 0; j < `WINO_OUT_N; j++) begin
				idx = 8'(t * TILE_WORDS + `WINO_IN_N * `WINO_IN_N + r * `WINO_OUT_N + j);
				r_out.data[j] = golden_mem[idx][15:0];
			end
			exp_q.push_back(r_out);
		end
	endtask

	task automatic count_cycle();
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			report_failure($sformatf("timeout after %0d cycles, %0d rows still expected",
				cycles, exp_q.size()));
	endtask

	// one clock: drive on the falling edge, check the beat taken at the next rise
	task automatic step();
		bit bubble;
		@(negedge clk);
		count_cycle();
		if (in_go)
			void'(in_q.pop_front());
		bubble = stall_en && (($random(seed) & 32'd3) == 32'd0);
		if (in_q.size() > 0 && !bubble) begin
			i_valid = 1'b1;
			i_row = in_q[0];
		end else begin
			i_valid = 1'b0;
		end
		in_go = i_valid && o_ready;
		i_ready = !out_hold && !(stall_en && (($random(seed) & 32'd3) == 32'd0));
		if (o_valid && i_ready) begin
			if (exp_q.size() == 0)
				report_failure($sformatf("output row at %0t with nothing expected", $time));
			compare_row(o_row, exp_q.pop_front());
			rows_checked++;
		end
	endtask

	task automatic apply_reset();
		in_q.delete();
		in_go = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			count_cycle();
			i_reset = 1'b1;
			i_valid = 1'b0;
			i_ready = 1'b1;
		end
		@(negedge clk);
		i_reset = 1'b0;
	endtask

	task automatic drain();
		while (in_q.size() > 0 || exp_q.size() > 0)
			step();
	endtask

	initial begin
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_row = '0;
		i_ready = 1'b0;
		seed = 32'h5031_67bd;
		in_go = 1'b0;
		stall_en = 1'b0;
		out_hold = 1'b0;
		cycles = 0;
		rows_checked = 0;
		$readmemh("dv/winograd_golden.txt", golden_mem);
		apply_reset();

		load_tile(0, `WINO_IN_N, 1'b1); // one tile alone
		drain();
		for (int t = 0; t < 4; t++)
			load_tile(t, `WINO_IN_N, 1'b1);
		drain();

		stall_en = 1'b1; // bubbles in, stalls out
		for (int t = 0; t < 4; t++)
			load_tile(t, `WINO_IN_N, 1'b1);
		drain();

		// reset with one tile held at the output and half a tile loaded
		stall_en = 1'b0;
		out_hold = 1'b1;
		load_tile(3, `WINO_IN_N, 1'b0);
		load_tile(1, 3, 1'b0);
		drain();
		while (!o_valid)
			step();
		apply_reset();
		out_hold = 1'b0;
		repeat (IDLE_CYCLES) begin
			step();
			compare_idle();
		end
		load_tile(2, `WINO_IN_N, 1'b1);
		drain();
		repeat (IDLE_CYCLES) begin // no stale tile left in either lane
			step();
			compare_idle();
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verilog
verilog/winograd_pkg.sv
verilog/winograd_adder_tree.sv
verilog/winograd_inverse_lane.sv
verilog/tile_dispatcher.sv
verilog/tile_collector.sv
verilog/winograd_output_stage.sv
dv/winograd_output_assertions.sv
dv/tb_winograd_output_stage.sv

/* Makefile */
TOP = tb_winograd_output_stage

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run:
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/winograd_golden.txt */
// per tile: six input rows of six 30-bit words M[r][0..5],
// then four output rows of four 16-bit words Y[k][0..3]
// tile 0: single element in M[0][0]
00012300 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
0123 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
// tile 1: M[1][1] spreads to every output
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00004500 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
0045 0045 0045 0045
0045 0045 0045 0045
0045 0045 0045 0045
0045 0045 0045 0045
// tile 2: signed M[2][2] plus scaled M[3][3], negative sums clamp to zero
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00100000 00000000 00000000 00000000
00000000 00000000 00000000 00000100 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
1001 0000 1004 0000
0000 1004 0000 1010
1004 0000 1010 0000
0000 1010 0000 1040
// tile 3: guard bits dropped in Y[0][0], Y[3][3] wraps past bit 29
0F012300 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000100 00000000
00000000 00000000 00000000 00000000 00000000 1FFFFF00
0124 0000 0004 0000
0000 0004 0000 0010
0004 0000 0010 0000
0000 0010 0000 0000
